/* files.f */
rtl/mips_pkg.sv
rtl/mips_ifs.sv
rtl/exec_ctrl.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/mem_port.sv
rtl/mips_exec_unit.sv
test/clk_gen.sv
test/mips_exec_assertions.sv
test/tb_mips_exec_unit.sv

/* run.sh */
#!/usr/bin/env bash
# builds and runs the testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module tb_mips_exec_unit -o tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" sim.log; then
	exit 1
fi
exit 0

/* test/tb_mips_exec_unit.sv */
`timescale 1ns/1ps

module tb_mips_exec_unit;

	localparam int ADDR_W = 10;

	typedef struct packed {
		mips_pkg::word_t instr;
		mips_pkg::word_t exp_data;
		logic store;
		logic [ADDR_W-1:0] exp_addr;
		logic [3:0] hold;
	} row_t;

	logic clk, reset;
	logic in_valid, in_ack, out_valid, out_ack;
	mips_pkg::word_t in_instr, out_data;
	logic mem_en, mem_we, mem_ack;
	logic [ADDR_W-1:0] mem_addr;
	mips_pkg::word_t mem_wdata, mem_rdata;

	mips_pkg::word_t mem [0:(1 << ADDR_W) - 1];
	logic [ADDR_W-1:0] last_waddr;
	mips_pkg::word_t last_wdata;
	int wr_count;
	int mem_delay;
	logic mem_busy;

	row_t rows [$];
	int errors;
	int checks;

	clk_gen clk_gen_inst (
		.clk   (clk),
		.reset (reset)
	);

	mips_exec_unit #(.ADDR_W(ADDR_W)) mips_exec_unit_inst (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_instr  (in_instr),
		.in_ack    (in_ack),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ack   (out_ack),
		.mem_en    (mem_en),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_ack   (mem_ack)
	);

	// memory model that answers after 0 to 3 cycles.
	always @(negedge clk)
	begin
		if (reset || mem_ack)
		begin
			mem_ack = 1'b0;
			mem_busy = 1'b0;
		end
		else if (mem_en)
		begin
			if (!mem_busy)
			begin
				mem_busy = 1'b1;
				mem_delay = $urandom % 4;
			end
			if (mem_delay == 0)
			begin
				mem_ack = 1'b1;
				if (mem_we)
				begin
					mem[mem_addr] = mem_wdata;
					last_waddr = mem_addr;
					last_wdata = mem_wdata;
					wr_count++;
				end
				else
					mem_rdata = mem[mem_addr];
			end
			else
				mem_delay--;
		end
	end

	task automatic check_word(input string name, input mips_pkg::word_t got,
			input mips_pkg::word_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
			input logic [ADDR_W-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	function automatic mips_pkg::word_t enc_r(int rs, int rt, int rd, int sh, logic [5:0] fn);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
	endfunction

	function automatic mips_pkg::word_t enc_i(logic [5:0] op, int rs, int rt, logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	task automatic add_row(input mips_pkg::word_t instr, input mips_pkg::word_t exp_data,
			input logic store, input logic [ADDR_W-1:0] exp_addr, input int hold);
		row_t r;
		r.instr = instr;
		r.exp_data = exp_data;
		r.store = store;
		r.exp_addr = exp_addr;
		r.hold = hold[3:0];
		rows.push_back(r);
	endtask

	// opcodes addi 08, lw 23, sw 2b.
	task automatic build_table();
		add_row(enc_i(6'h08, 0, 1, 16'h1234), 32'h00001234, 0, 0, 0);
		add_row(enc_i(6'h08, 0, 2, 16'hfffb), 32'hfffffffb, 0, 0, 0);
		add_row(enc_i(6'h08, 0, 3, 16'h7f00), 32'h00007f00, 0, 0, 0);
		add_row(enc_i(6'h08, 0, 4, 16'h8000), 32'hffff8000, 0, 0, 3);
		add_row(enc_r(1, 2, 5, 0, 6'h20), 32'h0000122f, 0, 0, 0);
		add_row(enc_r(1, 3, 6, 0, 6'h21), 32'h00009134, 0, 0, 0);
		add_row(enc_r(1, 3, 7, 0, 6'h22), 32'hffff9334, 0, 0, 0);
		add_row(enc_r(3, 1, 8, 0, 6'h23), 32'h00006ccc, 0, 0, 0);
		add_row(enc_r(1, 3, 9, 0, 6'h24), 32'h00001200, 0, 0, 0);
		add_row(enc_r(1, 3, 10, 0, 6'h25), 32'h00007f34, 0, 0, 0);
		add_row(enc_r(1, 3, 11, 0, 6'h26), 32'h00006d34, 0, 0, 0);
		add_row(enc_r(1, 3, 12, 0, 6'h27), 32'hffff80cb, 0, 0, 0);
		// slt with negative operands.
		add_row(enc_r(2, 1, 13, 0, 6'h2a), 32'h00000001, 0, 0, 0);
		add_row(enc_r(1, 2, 14, 0, 6'h2a), 32'h00000000, 0, 0, 0);
		add_row(enc_r(4, 2, 15, 0, 6'h2a), 32'h00000001, 0, 0, 0);
		add_row(enc_r(0, 1, 16, 4, 6'h00), 32'h00012340, 0, 0, 0);
		add_row(enc_r(0, 2, 17, 8, 6'h02), 32'h00ffffff, 0, 0, 0);
		add_row(enc_r(0, 4, 18, 4, 6'h03), 32'hfffff800, 0, 0, 0);
		// byte addresses 0x7f10 and 0x7ef8 map to word addresses 3c4 and 3be.
		add_row(enc_i(6'h2b, 3, 2, 16'h0010), 32'hfffffffb, 1, 10'h3c4, 4);
		add_row(enc_i(6'h23, 3, 19, 16'h0010), 32'hfffffffb, 0, 0, 0);
		add_row(enc_i(6'h2b, 3, 6, 16'hfff8), 32'h00009134, 1, 10'h3be, 0);
		add_row(enc_i(6'h23, 3, 20, 16'hfff8), 32'h00009134, 0, 0, 0);
		add_row(enc_i(6'h23, 0, 21, 16'h0040), 32'hc0de0010, 0, 0, 0);
		// $zero keeps its value.
		add_row(enc_r(1, 3, 0, 0, 6'h20), 32'h00009134, 0, 0, 2);
		add_row(enc_r(0, 1, 22, 0, 6'h20), 32'h00001234, 0, 0, 0);
		// unknown opcode and function code both aimed at $1.
		add_row(enc_i(6'h3f, 0, 1, 16'h5555), 32'h00000000, 0, 0, 2);
		add_row(enc_r(1, 3, 1, 0, 6'h3f), 32'h00000000, 0, 0, 0);
		add_row(enc_r(1, 0, 23, 0, 6'h25), 32'h00001234, 0, 0, 0);
	endtask

	task automatic apply_row(input int n);
		row_t r;
		mips_pkg::word_t held;
		int wr_before;
		r = rows[n];
		wr_before = wr_count;
		in_instr = r.instr;
		in_valid = 1'b1;
		do
			@(negedge clk);
		while (!in_ack);
		in_valid = 1'b0;
		while (!out_valid)
			@(negedge clk);
		check_word("out_data", out_data, r.exp_data);
		if (r.store)
		begin
			if (wr_count != wr_before + 1)
				report_failure("the store never reached the memory");
			check_addr("mem_addr", last_waddr, r.exp_addr);
			check_word("mem_wdata", last_wdata, r.exp_data);
		end
		else if (wr_count != wr_before)
			report_failure("the memory was written by an instruction that is not a store");
		// next instruction is offered while the result waits.
		held = out_data;
		for (int h = 0; h < r.hold; h++)
		begin
			if (n + 1 < rows.size())
			begin
				in_instr = rows[n + 1].instr;
				in_valid = 1'b1;
			end
			@(negedge clk);
			if (!out_valid || in_ack)
				report_failure("the result was not held while out_ack stayed low");
			check_word("out_data", out_data, held);
		end
		out_ack = 1'b1;
		@(negedge clk);
		out_ack = 1'b0;
		if (out_valid)
			report_failure("out_valid stayed high after out_ack");
	endtask

	initial
	begin
		int err_before;
		void'($urandom(32'ha8d5fc57));
		in_valid = 1'b0;
		in_instr = '0;
		out_ack = 1'b0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		mem_busy = 1'b0;
		mem_delay = 0;
		wr_count = 0;
		errors = 0;
		checks = 0;
		for (int i = 0; i < (1 << ADDR_W); i++)
			mem[i] = 32'hc0de0000 + i;
		build_table();
		@(negedge reset);
		@(negedge clk);
		check_word("out_data", out_data, '0);
		if (in_ack || out_valid || mem_en || mem_we)
			report_failure("a control output is high after reset");
		for (int n = 0; n < rows.size(); n++)
		begin
			err_before = errors;
			apply_row(n);
			if (errors == err_before)
				$display("row %0d instr %h: ok", n, rows[n].instr);
			else
				$display("row %0d instr %h: failed", n, rows[n].instr);
		end
		$display("%0d rows, %0d checks, %0d failed checks", rows.size(), checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// watchdog allows 40 cycles per row plus margin.
	initial
	begin
		@(negedge reset);
		repeat (rows.size() * 40 + 100) @(posedge clk);
		$display("Timeout: the DUT stopped answering before all rows finished");
		$display("Errors found");
		$finish;
	end

endmodule

/* test/mips_exec_assertions.sv */
`timescale 1ns/1ps

module mips_exec_assertions #(
	parameter int ADDR_W = 10
) (
	input logic clk,
	input logic reset,
	input logic in_ack,
	input logic out_valid,
	input logic out_ack,
	input mips_pkg::word_t out_data,
	input logic mem_en,
	input logic mem_ack,
	input logic [ADDR_W-1:0] mem_addr,
	input mips_pkg::word_t mem_wdata,
	input mips_pkg::state_e state
);

	// one accept pulse per instruction.
	ack_pulse: assert property (@(posedge clk) disable iff (reset) in_ack |=> !in_ack)
		else $error("in_ack high for two cycles in a row");

	// the memory enable is only up while the controller waits for done.
	mem_state: assert property (@(posedge clk) disable iff (reset)
		mem_en |-> state == mips_pkg::MEM_WAIT)
		else $error("mem_en high outside of MEM_WAIT");

	out_hold: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ack |=> out_valid && $stable(out_data))
		else $error("result dropped or changed before out_ack");

	mem_hold: assert property (@(posedge clk) disable iff (reset)
		mem_en && !mem_ack |=> mem_en && $stable(mem_addr) && $stable(mem_wdata))
		else $error("memory request changed before mem_ack");

endmodule

bind mips_exec_unit mips_exec_assertions #(.ADDR_W(ADDR_W)) mips_exec_assertions_inst (
	.clk       (clk),
	.reset     (reset),
	.in_ack    (in_ack),
	.out_valid (out_valid),
	.out_ack   (out_ack),
	.out_data  (out_data),
	.mem_en    (mem_en),
	.mem_ack   (mem_ack),
	.mem_addr  (mem_addr),
	.mem_wdata (mem_wdata),
	.state     (exec_ctrl_inst.state)
);

/* test/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic reset
);

	// reset is held over the first two rising edges.
	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

	always #20 clk = ~clk;

endmodule

/* rtl/mips_exec_unit.sv */
`timescale 1ns/1ps

module mips_exec_unit #(
	parameter int ADDR_W = 10
) (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  mips_pkg::word_t in_instr,
	output logic in_ack,
	output logic out_valid,
	output mips_pkg::word_t out_data,
	input  logic out_ack,
	output logic mem_en,
	output logic mem_we,
	output logic [ADDR_W-1:0] mem_addr,
	output mips_pkg::word_t mem_wdata,
	input  mips_pkg::word_t mem_rdata,
	input  logic mem_ack
);

	regfile_if rf_bus ();
	alu_if alu_bus ();
	mem_req_if #(.ADDR_W(ADDR_W)) mem_bus ();

	// one instruction in flight at a time.
	exec_ctrl exec_ctrl_inst (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_instr  (in_instr),
		.in_ack    (in_ack),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ack   (out_ack),
		.rf        (rf_bus.ctrl),
		.au        (alu_bus.ctrl),
		.mr        (mem_bus.ctrl)
	);

	reg_file reg_file_inst (
		.clk   (clk),
		.reset (reset),
		.rf    (rf_bus.regs)
	);

	alu alu_inst (
		.au (alu_bus.unit)
	);

	// word-addressed memory side.
	mem_port #(.ADDR_W(ADDR_W)) mem_port_inst (
		.clk       (clk),
		.reset     (reset),
		.mr        (mem_bus.port),
		.mem_en    (mem_en),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_ack   (mem_ack)
	);

endmodule

/* rtl/mem_port.sv */
`timescale 1ns/1ps

module mem_port #(
	parameter int ADDR_W = 10
) (
	input  logic clk,
	input  logic reset,
	mem_req_if.port mr,
	output logic mem_en,
	output logic mem_we,
	output logic [ADDR_W-1:0] mem_addr,
	output mips_pkg::word_t mem_wdata,
	input  mips_pkg::word_t mem_rdata,
	input  logic mem_ack
);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			mem_en <= 1'b0;
			mem_we <= 1'b0;
			mr.done <= 1'b0;
		end
		else
		begin
			mr.done <= 1'b0;
			if (!mem_en && mr.start)
			begin
				mem_en <= 1'b1;
				mem_we <= mr.we;
				mem_addr <= mr.word_addr;
				mem_wdata <= mr.wdata;
			end
			else if (mem_en && mem_ack)
			begin
				// read data is sampled together with the ack.
				mr.rdata <= mem_rdata;
				mem_en <= 1'b0;
				mem_we <= 1'b0;
				mr.done <= 1'b1;
			end
		end
	end

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu (
	alu_if.unit au
);

	logic less;

	// signed compare for slt.
	assign less = $signed(au.a) < $signed(au.b);

	always_comb
	begin
		case (au.op)
			mips_pkg::ALU_ADD: au.result = au.a + au.b;
			mips_pkg::ALU_SUB: au.result = au.a - au.b;
			mips_pkg::ALU_AND: au.result = au.a & au.b;
			mips_pkg::ALU_OR:  au.result = au.a | au.b;
			mips_pkg::ALU_XOR: au.result = au.a ^ au.b;
			mips_pkg::ALU_NOR: au.result = ~(au.a | au.b);
			mips_pkg::ALU_SLT: au.result = {{(mips_pkg::XLEN-1){1'b0}}, less};
			// shifts act on rt, which arrives on b.
			mips_pkg::ALU_SLL: au.result = au.b << au.shamt;
			mips_pkg::ALU_SRL: au.result = au.b >> au.shamt;
			mips_pkg::ALU_SRA: au.result = $signed(au.b) >>> au.shamt;
			default: au.result = '0;
		endcase
	end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input logic reset,
	regfile_if.regs rf
);

	// $zero has no storage.
	mips_pkg::word_t regs [1:31];

	assign rf.rs_data = (rf.rs_idx == 5'd0) ? '0 : regs[rf.rs_idx];
	assign rf.rt_data = (rf.rt_idx == 5'd0) ? '0 : regs[rf.rt_idx];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 1; i < 32; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (rf.wr_en && rf.wr_idx != 5'd0)
		begin
			regs[rf.wr_idx] <= rf.wr_data;
		end
	end

endmodule

/* rtl/exec_ctrl.sv */
`timescale 1ns/1ps

module exec_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  mips_pkg::word_t in_instr,
	output logic in_ack,
	output logic out_valid,
	output mips_pkg::word_t out_data,
	input  logic out_ack,
	regfile_if.ctrl rf,
	alu_if.ctrl au,
	mem_req_if.ctrl mr
);

	mips_pkg::state_e state;
	mips_pkg::word_t instr_q, s_q, t_q, d_q;
	mips_pkg::word_t imm_sext;
	mips_pkg::opcode_e opcode;
	mips_pkg::funct_e funct;
	mips_pkg::alu_op_e alu_op;
	mips_pkg::reg_idx_t dest;
	logic use_imm, is_mem, is_store, legal;
	logic start_q;

	assign opcode = mips_pkg::opcode_e'(instr_q[31:26]);
	assign funct = mips_pkg::funct_e'(instr_q[5:0]);
	assign imm_sext = {{(mips_pkg::XLEN-16){instr_q[15]}}, instr_q[15:0]};

	// decode of the captured instruction.
	always_comb
	begin
		alu_op = mips_pkg::ALU_ADD;
		dest = instr_q[20:16];
		use_imm = 1'b1;
		is_mem = 1'b0;
		is_store = 1'b0;
		legal = 1'b1;
		case (opcode)
			mips_pkg::OP_RTYPE:
			begin
				use_imm = 1'b0;
				dest = instr_q[15:11];
				case (funct)
					mips_pkg::FN_ADD, mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB, mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:  alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR: alu_op = mips_pkg::ALU_XOR;
					mips_pkg::FN_NOR: alu_op = mips_pkg::ALU_NOR;
					mips_pkg::FN_SLT: alu_op = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLL: alu_op = mips_pkg::ALU_SLL;
					mips_pkg::FN_SRL: alu_op = mips_pkg::ALU_SRL;
					mips_pkg::FN_SRA: alu_op = mips_pkg::ALU_SRA;
					default: legal = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDI: ;
			mips_pkg::OP_LW: is_mem = 1'b1;
			mips_pkg::OP_SW:
			begin
				is_mem = 1'b1;
				is_store = 1'b1;
			end
			default: legal = 1'b0;
		endcase
	end

	assign rf.rs_idx = instr_q[25:21];
	assign rf.rt_idx = instr_q[20:16];
	assign rf.wr_en = (state == mips_pkg::WRITE_BACK) && legal && !is_store;
	assign rf.wr_idx = dest;
	assign rf.wr_data = d_q;

	// lw and sw use the adder for the effective byte address.
	assign au.op = alu_op;
	assign au.a = s_q;
	assign au.b = use_imm ? imm_sext : t_q;
	assign au.shamt = instr_q[10:6];

	assign mr.start = start_q;
	assign mr.we = is_store;
	assign mr.byte_addr = au.result;
	assign mr.wdata = t_q;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= mips_pkg::IDLE;
			in_ack <= 1'b0;
			out_valid <= 1'b0;
			out_data <= '0;
			start_q <= 1'b0;
		end
		else
		begin
			in_ack <= 1'b0;
			start_q <= 1'b0;
			case (state)
				mips_pkg::IDLE:
				if (in_valid)
				begin
					instr_q <= in_instr;
					in_ack <= 1'b1;
					state <= mips_pkg::READ_REGS;
				end
				mips_pkg::READ_REGS:
				begin
					s_q <= rf.rs_data;
					t_q <= rf.rt_data;
					state <= mips_pkg::EXECUTE;
				end
				mips_pkg::EXECUTE:
				if (is_mem && legal)
				begin
					start_q <= 1'b1;
					state <= mips_pkg::MEM_WAIT;
				end
				else
				begin
					// unknown codes return zero.
					d_q <= legal ? au.result : '0;
					state <= mips_pkg::WRITE_BACK;
				end
				mips_pkg::MEM_WAIT:
				if (mr.done)
				begin
					d_q <= is_store ? t_q : mr.rdata;
					state <= mips_pkg::WRITE_BACK;
				end
				mips_pkg::WRITE_BACK:
				begin
					out_data <= d_q;
					out_valid <= 1'b1;
					state <= mips_pkg::WAIT_ACK;
				end
				mips_pkg::WAIT_ACK:
				if (out_ack)
				begin
					out_valid <= 1'b0;
					state <= mips_pkg::IDLE;
				end
				default: state <= mips_pkg::IDLE;
			endcase
		end
	end

endmodule

/* rtl/mips_ifs.sv */
`timescale 1ns/1ps

interface regfile_if;
	mips_pkg::reg_idx_t rs_idx;
	mips_pkg::reg_idx_t rt_idx;
	mips_pkg::word_t rs_data;
	mips_pkg::word_t rt_data;
	logic wr_en;
	mips_pkg::reg_idx_t wr_idx;
	mips_pkg::word_t wr_data;

	modport ctrl (output rs_idx, rt_idx, wr_en, wr_idx, wr_data, input rs_data, rt_data);
	modport regs (input rs_idx, rt_idx, wr_en, wr_idx, wr_data, output rs_data, rt_data);
endinterface

interface alu_if;
	mips_pkg::alu_op_e op;
	mips_pkg::word_t a;
	mips_pkg::word_t b;
	logic [4:0] shamt;
	mips_pkg::word_t result;

	modport ctrl (output op, a, b, shamt, input result);
	modport unit (input op, a, b, shamt, output result);
endinterface

interface mem_req_if #(parameter int ADDR_W = 10);
	logic start;
	logic we;
	mips_pkg::word_t byte_addr;
	mips_pkg::word_t wdata;
	mips_pkg::word_t rdata;
	logic done;
	logic [ADDR_W-1:0] word_addr;

	// low two bits select a byte lane and are dropped.
	assign word_addr = byte_addr[ADDR_W+1:2];

	modport ctrl (output start, we, byte_addr, wdata, input rdata, done);
	modport port (input start, we, word_addr, wdata, output rdata, done);
endinterface

/* rtl/mips_pkg.sv */
package mips_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// primary opcodes, bits 31:26.
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// r-type function field, bits 5:0.
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_ADD  = 6'h20,
		FN_ADDU = 6'h21,
		FN_SUB  = 6'h22,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_e;

	typedef enum logic [2:0] {
		IDLE, READ_REGS, EXECUTE, MEM_WAIT, WRITE_BACK, WAIT_ACK
	} state_e;

endpackage
